/* hw/intr_pkg.sv */
package intr_pkg;

	// interrupt levels and mask groups
	localparam int n_irq = 32;
	localparam int n_mask = 10;
	localparam int n_chan = 16; // channel levels
	localparam int slot_chan_lo = 12; // first channel slot
	localparam int slot_tail_lo = slot_chan_lo + n_chan; // W-settable slots after channels
	localparam int n_tail = n_irq - slot_tail_lo;

	localparam int slot_cpu_hi = 3; // other CPU, high priority
	localparam int slot_cpu_lo = 29; // other CPU, low priority
	localparam int slot_soft_hi = 30;
	localparam int slot_soft_lo = 31;
	localparam int slot_unused = 11; // tied low

	// channel acknowledge timing, in clocks
	localparam int dok_dly_ticks = 4;
	localparam int dok_ticks = 6;
	localparam int dok_dly_w = $clog2(dok_dly_ticks + 1);
	localparam int dok_win_w = $clog2(dok_ticks + 1);

	// vector layout on dad
	localparam int vec_flag_bit = 4;
	localparam int vec_num_msb = 11; // slot number in bits 11..15
	localparam int vec_num_w = $clog2(n_irq);

	// mask bit gating each slot, -1 means never masked
	localparam int mask_group [0:n_irq-1] = '{
		-1,
		0, 1, 2, 3,
		4, 4, 4, 4, 4, 4, 4,
		5, 5, 6, 6,
		7, 7, 7, 7, 7, 7,
		8, 8, 8, 8, 8, 8,
		9, 9, 9, 9
	};

	typedef logic [0:n_irq-1] irq_vec_t; // slot 0 is highest priority
	typedef logic [0:n_mask-1] mask_vec_t;
	typedef logic [0:15] word_t; // bit 0 is the msb

endpackage

/* hw/chan_irq_if.sv */
`timescale 1ns/1ns

// channel and other-CPU requests, fetch block to cell array
interface chan_irq_if import intr_pkg::*; ();

	logic [0:n_chan-1] chan_req; // one-hot channel number
	logic cpu_hi; // other CPU, slot 3
	logic cpu_lo; // other CPU, slot 29
	logic window; // acknowledge window, qualifies the pulses

	modport src (
		output chan_req,
		output cpu_hi,
		output cpu_lo,
		output window
	);

	modport dst (
		input chan_req,
		input cpu_hi,
		input cpu_lo,
		input window
	);

endinterface

/* hw/intr_mask_reg.sv */
`timescale 1ns/1ns

module intr_mask_reg import intr_pkg::*; (
	input logic __clk,
	input logic arst_n,
	input logic clm, // general clear
	input logic load, // strob1 & w_rm
	input word_t w,
	input mask_vec_t zi, // lock-out pattern from the chain
	input logic serve,
	output mask_vec_t rs
);

	// clear beats serve, serve beats load
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			rs <= '0;
		end else if (clm) begin
			rs <= '0;
		end else if (serve) begin
			// groups at and below the serviced level get locked out
			rs <= rs & zi;
		end else if (load) begin
			rs <= w[0:n_mask-1]; // mask lives in W bits 0..9
		end
	end

endmodule

/* hw/intr_slot.sv */
`timescale 1ns/1ns

module intr_slot (
	input logic __clk,
	input logic arst_n,
	input logic imask, // mask bit for this level
	input logic src, // level source, sampled every clock
	input logic w_set, // W bus bit for software set
	input logic set_en, // software write strobe
	input logic clr,
	input logic serve,
	input logic prio_in,
	output logic rz,
	output logic sz,
	output logic rp,
	output logic prio_out
);

	assign sz = rz & imask; // masked request

	// chain passes only past an idle, unrequested level
	assign prio_out = prio_in & ~sz & ~rp;

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			rz <= 1'b0;
			rp <= 1'b0;
		end else begin
			// request bit, clear wins
			if (clr) begin
				rz <= 1'b0;
			end else if (src | (set_en & w_set)) begin
				rz <= 1'b1;
			end
			// service bit, drops with the cell's clear
			if (clr) begin
				rp <= 1'b0;
			end else if (serve & prio_in & sz) begin
				rp <= 1'b1; // only the chain head can get here
			end
		end
	end

endmodule

/* hw/intr_prio_array.sv */
`timescale 1ns/1ns

module intr_prio_array import intr_pkg::*; (
	input logic __clk,
	input logic arst_n,
	input irq_vec_t src, // asynchronous levels
	input word_t w,
	input logic strob1,
	input logic ck_rz_w,
	input logic zerrz,
	input logic clm,
	input logic i2,
	input logic k1,
	input logic sin,
	input logic ir14,
	input logic ir15,
	input logic serve,
	input logic zer, // head of the chain
	input mask_vec_t rs,
	chan_irq_if.dst chan,
	output irq_vec_t rp,
	output mask_vec_t zi,
	output word_t bus_rz,
	output logic irq
);

	irq_vec_t src_all, w_set, set_en, clr, imask;
	irq_vec_t rz, sz, prio_in, prio_out;
	logic soft_op, soft_hi, soft_lo, soft_clr;
	logic ck_rzw, clr_w, clr_ch;

	// software interrupt instruction
	assign soft_op = strob1 & sin;
	assign soft_hi = soft_op & ir14;
	assign soft_lo = soft_op & ir15;
	assign soft_clr = soft_op & ~ir14 & ~ir15; // neither bit, drop both

	assign ck_rzw = strob1 & ck_rz_w; // masked write from W
	assign clr_w = clm | zerrz;
	assign clr_ch = clm | k1 | (strob1 & i2); // i2 strobe drops latched channel requests

	always_comb begin
		src_all = src;
		src_all[slot_unused] = 1'b0;
		src_all[slot_cpu_hi] = src[slot_cpu_hi] | (chan.window & chan.cpu_hi);
		src_all[slot_cpu_lo] = src[slot_cpu_lo] | (chan.window & chan.cpu_lo);
		src_all[slot_chan_lo +: n_chan] = src[slot_chan_lo +: n_chan]
			| (chan.chan_req & {n_chan{chan.window}}); // pulses only count in the window
		src_all[slot_soft_hi] = src[slot_soft_hi] | soft_hi;
		src_all[slot_soft_lo] = src[slot_soft_lo] | soft_lo;
	end

	always_comb begin
		w_set = '0; // channel slots can't be written
		set_en = '0;
		clr = {n_irq{clr_w}};
		w_set[0 +: slot_chan_lo] = w[0 +: slot_chan_lo]; // W 0..11
		w_set[slot_tail_lo +: n_tail] = w[slot_chan_lo +: n_tail]; // W 12..15
		set_en[0 +: slot_chan_lo] = {slot_chan_lo{ck_rzw}};
		set_en[slot_tail_lo +: n_tail] = {n_tail{ck_rzw}};
		clr[slot_chan_lo +: n_chan] = {n_chan{clr_ch}};
		clr[slot_soft_hi] = clr_w | soft_clr;
		clr[slot_soft_lo] = clr_w | soft_clr;
	end

	assign prio_in = {zer, prio_out[0:n_irq-2]};

	genvar i;
	generate
		for (i = 0; i < n_irq; i++) begin : g_slot
			if (mask_group[i] < 0) begin : g_nmi
				assign imask[i] = 1'b1; // slot 0 can't be masked
			end else begin : g_msk
				assign imask[i] = rs[mask_group[i]];
			end
			intr_slot u_slot (
				.__clk(__clk),
				.arst_n(arst_n),
				.imask(imask[i]),
				.src(src_all[i]),
				.w_set(w_set[i]),
				.set_en(set_en[i]),
				.clr(clr[i]),
				.serve(serve),
				.prio_in(prio_in[i]),
				.rz(rz[i]),
				.sz(sz[i]),
				.rp(rp[i]),
				.prio_out(prio_out[i])
			);
		end
		// lock-out per group, taken at the group's last slot
		for (i = 1; i < n_irq - 1; i++) begin : g_zi
			if (mask_group[i] != mask_group[i + 1]) begin : g_end
				assign zi[mask_group[i]] = prio_out[i];
			end
		end
	endgenerate

	assign zi[n_mask-1] = prio_out[n_irq-1];

	assign bus_rz = {rz[0 +: slot_chan_lo], rz[slot_tail_lo +: n_tail]}; // user-visible only
	assign irq = |sz; // summed request

endmodule

/* hw/intr_vector_enc.sv */
`timescale 1ns/1ns

module intr_vector_enc import intr_pkg::*; (
	input irq_vec_t rp,
	input logic vec_rd,
	output word_t dad
);

	logic [vec_num_w-1:0] slot_num; // highest set service bit

	// scan from the bottom so slot 0 ends up winning
	always_comb begin
		slot_num = '0;
		for (int i = n_irq - 1; i >= 0; i--) begin
			if (rp[i]) begin
				slot_num = vec_num_w'(i);
			end
		end
	end

	always_comb begin
		dad = '0; // bus idle unless the vector is read
		if (vec_rd) begin
			dad[vec_flag_bit] = 1'b1; // vector fetch flag
			dad[vec_num_msb +: vec_num_w] = slot_num; // msb first in bit 11
		end
	end

endmodule

/* hw/chan_irq_fetch.sv */
`timescale 1ns/1ns

module chan_irq_fetch import intr_pkg::*; (
	input logic __clk,
	input logic arst_n,
	input logic rin, // channel interrupt request
	input logic zgpn_,
	input word_t rdt,
	chan_irq_if.src chan,
	output logic dok
);

	logic rin_q;
	logic [dok_dly_w-1:0] dly_cnt; // delay before the window
	logic [dok_win_w-1:0] win_cnt; // remaining window clocks
	logic ack; // acknowledge flag
	logic first; // first window clock

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			rin_q <= 1'b0;
			dly_cnt <= '0;
			win_cnt <= '0;
			ack <= 1'b0;
		end else begin
			rin_q <= rin;
			if (!rin) begin
				dly_cnt <= '0; // abort
				win_cnt <= '0;
			end else if (~rin_q) begin
				dly_cnt <= dok_dly_w'(dok_dly_ticks); // rin just rose
			end else if (dly_cnt != '0) begin
				dly_cnt <= dly_cnt - 1'b1;
				if (dly_cnt == dok_dly_w'(1)) begin
					win_cnt <= dok_win_w'(dok_ticks); // open the window
				end
			end else if (win_cnt != '0) begin
				win_cnt <= win_cnt - 1'b1;
			end
			// flag taken at window start, held until rin drops
			if (!rin) begin
				ack <= 1'b0;
			end else if (first) begin
				ack <= ~rdt[15] | zgpn_;
			end
		end
	end

	assign chan.window = rin & (win_cnt != '0);
	assign first = rin & (win_cnt == dok_win_w'(dok_ticks));

	// channel number from rdt 11..14 when bit 15 is low
	always_comb begin
		chan.chan_req = '0;
		if (first & ~rdt[15]) begin
			chan.chan_req[rdt[11:14]] = 1'b1;
		end
	end

	assign chan.cpu_hi = first & rdt[15] & ~rdt[0]; // other CPU requests
	assign chan.cpu_lo = first & rdt[15] & rdt[0];

	assign dok = rin & ack; // falls with rin in the same cycle

endmodule

/* hw/intr_unit.sv */
`timescale 1ns/1ns

module intr_unit import intr_pkg::*; (
	input logic __clk,
	input logic arst_n,
	// strobes and clears
	input logic strob1,
	input logic w_rm,
	input logic ck_rz_w,
	input logic zerrz,
	input logic clm,
	// CPU states
	input logic i2,
	input logic k1,
	input logic i4,
	input logic serve, // i1 & przerw
	input logic zer,
	// software interrupt
	input logic sin,
	input logic ir14,
	input logic ir15,
	// asynchronous levels
	input logic pout, // power out
	input logic b_parz, // memory parity error
	input logic b_p0, // no memory
	input logic rpa, // interface power out
	input logic zegar, // timer
	input logic xi, // illegal instruction
	input logic fi0,
	input logic fi1,
	input logic fi2,
	input logic fi3,
	input logic oprq, // operator request
	// channel fetch
	input logic rin,
	input logic zw, // bus grant
	input logic zgpn_,
	input word_t w,
	input word_t rdt,
	input logic vec_rd,
	output logic irq,
	output logic przerw_z,
	output mask_vec_t rs,
	output word_t bus_rz,
	output logic dok,
	output word_t dad
);

	irq_vec_t src, rp;
	mask_vec_t zi;
	logic mask_clr;
	logic fetch_rin;

	chan_irq_if chan_bus ();

	// slots fed by channels, other CPU and software stay zero here
	assign src = {
		pout, b_parz, b_p0, 1'b0, rpa, zegar, xi, fi0, fi1, fi2, fi3,
		1'b0, // unused
		{n_chan{1'b0}},
		oprq, 1'b0, 1'b0, 1'b0
	};

	assign mask_clr = clm | (strob1 & i4); // i4 also wipes the mask
	assign fetch_rin = rin & zw; // fetch only while the bus is granted
	assign przerw_z = zi[4] & ~zi[8]; // chain stops on a channel level

	intr_mask_reg u_mask (
		.__clk(__clk),
		.arst_n(arst_n),
		.clm(mask_clr),
		.load(strob1 & w_rm),
		.w(w),
		.zi(zi),
		.serve(serve),
		.rs(rs)
	);

	intr_prio_array u_array (
		.__clk(__clk),
		.arst_n(arst_n),
		.src(src),
		.w(w),
		.strob1(strob1),
		.ck_rz_w(ck_rz_w),
		.zerrz(zerrz),
		.clm(clm),
		.i2(i2),
		.k1(k1),
		.sin(sin),
		.ir14(ir14),
		.ir15(ir15),
		.serve(serve),
		.zer(zer),
		.rs(rs),
		.chan(chan_bus),
		.rp(rp),
		.zi(zi),
		.bus_rz(bus_rz),
		.irq(irq)
	);

	intr_vector_enc u_vec (
		.rp(rp),
		.vec_rd(vec_rd),
		.dad(dad)
	);

	chan_irq_fetch u_fetch (
		.__clk(__clk),
		.arst_n(arst_n),
		.rin(fetch_rin),
		.zgpn_(zgpn_),
		.rdt(rdt),
		.chan(chan_bus),
		.dok(dok)
	);

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
	output logic __clk,
	output logic arst_n
);

	initial begin
		__clk = 1'b0;
		forever #4 __clk = ~__clk; // 8 ns period
	end

	// reset over two rising edges, released on a falling edge
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge __clk);
		@(negedge __clk);
		arst_n = 1'b1;
	end

endmodule

/* verif/intr_unit_chk.sv */
`timescale 1ns/1ns

module intr_unit_chk import intr_pkg::*; (
	input logic __clk,
	input logic arst_n,
	input logic rin,
	input logic clm,
	input logic dok,
	input logic vec_rd,
	input logic irq,
	input word_t bus_rz,
	input word_t dad
);

	logic chan_seen; // channel fetch since the last general clear

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			chan_seen <= 1'b0;
		end else if (clm) begin
			chan_seen <= rin; // clear drops channel and other-CPU slots too
		end else if (rin) begin
			chan_seen <= 1'b1;
		end
	end

	// acknowledge only while the request is up
	dok_needs_rin: assert property (@(posedge __clk) disable iff (!arst_n) dok |-> rin)
		else $error("dok high while rin is low");

	vec_flag_needs_rd: assert property (@(posedge __clk) disable iff (!arst_n)
		dad[vec_flag_bit] |-> vec_rd)
		else $error("vector flag on dad without vec_rd");

	// irq needs a visible request or a channel-side slot
	irq_has_source: assert property (@(posedge __clk) disable iff (!arst_n)
		irq |-> ((bus_rz != '0) || chan_seen))
		else $error("irq high with no request behind it");

endmodule

/* verif/intr_unit_tb.sv */
`timescale 1ns/1ns

module intr_unit_tb import intr_pkg::*; ();

	logic __clk, arst_n;
	logic strob1, w_rm, ck_rz_w, zerrz, clm;
	logic i2, k1, i4, serve, zer;
	logic sin, ir14, ir15;
	logic pout, b_parz, b_p0, rpa, zegar, xi, fi0, fi1, fi2, fi3, oprq;
	logic rin, zw, zgpn_, vec_rd;
	word_t w, rdt;
	logic irq, przerw_z, dok;
	mask_vec_t rs;
	word_t bus_rz, dad;
	logic [31:0] rng; // xorshift state

	tb_clk_gen u_clk (.__clk(__clk), .arst_n(arst_n));

	intr_unit DUT (.*);

	bind intr_unit intr_unit_chk u_chk (
		.__clk(__clk),
		.arst_n(arst_n),
		.rin(rin),
		.clm(clm),
		.dok(dok),
		.vec_rd(vec_rd),
		.irq(irq),
		.bus_rz(bus_rz),
		.dad(dad)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// mask bit gating a slot, -1 for slot 0
	function automatic int slot_group(input int s);
		if (s == 0) return -1;
		else if (s <= 4) return s - 1;
		else if (s <= 11) return 4;
		else if (s <= 13) return 5;
		else if (s <= 15) return 6;
		else if (s <= 21) return 7;
		else if (s <= 27) return 8;
		else return 9;
	endfunction

	// W and bus_rz bit b (0 is the msb) to slot
	function automatic int bus_slot(input int b);
		return (b < 12) ? b : b + 16;
	endfunction

	function automatic logic exp_irq(input logic [15:0] req, input logic [9:0] mask);
		int g;
		logic any;
		any = 1'b0;
		for (int b = 0; b < 16; b++) begin
			g = slot_group(bus_slot(b));
			if (req[15 - b] && (g < 0)) any = 1'b1; // never masked
			else if (req[15 - b] && mask[9 - g]) any = 1'b1;
		end
		return any;
	endfunction

	// full mask minus every group holding a slot at or below p
	function automatic logic [9:0] exp_rs_after(input int p);
		logic [9:0] keep;
		keep = 10'h3ff;
		for (int s = p; s < 32; s++) begin
			if (slot_group(s) >= 0) keep[9 - slot_group(s)] = 1'b0;
		end
		return keep;
	endfunction

	function automatic logic [15:0] vector(input int slot);
		return (16'h8000 >> vec_flag_bit) | 16'(slot); // flag plus slot in bits 11..15
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) stop_run($sformatf("Fail: %s is %h, expected %h", name, got, exp));
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (arst_n !== 1'b1) begin
			if (n == 5) stop_run("Timed out waiting for reset to be released");
			@(negedge __clk);
			n++;
		end
		@(negedge __clk);
	endtask

	task automatic wait_dok();
		int n;
		n = 0;
		while (dok !== 1'b1) begin
			if (n == 20) stop_run("Timed out waiting for dok to rise");
			@(negedge __clk);
			n++;
		end
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (irq !== 1'b1) begin
			if (n == 10) stop_run("Timed out waiting for irq to rise");
			@(negedge __clk);
			n++;
		end
	endtask

	task automatic init_inputs();
		{strob1, w_rm, ck_rz_w, zerrz, clm, i2, k1, i4, serve} = '0;
		zer = 1'b1; // chain head always enabled
		{sin, ir14, ir15} = '0;
		{pout, b_parz, b_p0, rpa, zegar, xi, fi0, fi1, fi2, fi3, oprq} = '0;
		{rin, zw, zgpn_, vec_rd} = '0;
		w = '0;
		rdt = '0;
	endtask

	// all drive tasks start and end just after a falling edge
	task automatic load_mask(input logic [15:0] val);
		w = val;
		strob1 = 1'b1;
		w_rm = 1'b1;
		@(negedge __clk);
		strob1 = 1'b0;
		w_rm = 1'b0;
	endtask

	task automatic write_req(input logic [15:0] val);
		w = val;
		strob1 = 1'b1;
		ck_rz_w = 1'b1;
		@(negedge __clk);
		strob1 = 1'b0;
		ck_rz_w = 1'b0;
	endtask

	task automatic clear_all();
		clm = 1'b1;
		@(negedge __clk);
		clm = 1'b0;
	endtask

	task automatic serve_once();
		serve = 1'b1;
		@(negedge __clk);
		serve = 1'b0;
	endtask

	task automatic soft_int(input logic hi, input logic lo);
		strob1 = 1'b1;
		sin = 1'b1;
		ir14 = hi;
		ir15 = lo;
		@(negedge __clk);
		{strob1, sin, ir14, ir15} = '0;
	endtask

	task automatic test_reset();
		check_value("irq", irq, 0);
		check_value("dok", dok, 0);
		check_value("przerw_z", przerw_z, 0);
		check_value("rs", rs, 0);
		check_value("bus_rz", bus_rz, 0);
		check_value("dad", dad, 0);
	endtask

	task automatic test_mask();
		logic [15:0] val;
		rng = xorshift(rng);
		val = rng[15:0];
		load_mask(val);
		check_value("rs", rs, val[15:6]); // W bits 0..9
		clear_all();
		check_value("rs", rs, 0);
	endtask

	task automatic test_soft_req();
		logic [15:0] req;
		logic [9:0] mask;
		repeat (4) begin
			rng = xorshift(rng);
			mask = rng[9:0];
			req = rng[31:16];
			load_mask({mask, 6'b0});
			write_req(req);
			check_value("bus_rz", bus_rz, req);
			check_value("irq", irq, exp_irq(req, mask));
			zerrz = 1'b1;
			@(negedge __clk);
			zerrz = 1'b0;
			check_value("bus_rz", bus_rz, 0);
			check_value("irq", irq, 0);
			clear_all();
		end
	endtask

	task automatic test_service();
		logic [15:0] req;
		int p;
		for (int r = 0; r < 3; r++) begin
			rng = xorshift(rng);
			req = rng[15:0] >> (5 * r); // push the winner further down each round
			if (req == 0) req = 16'h0001;
			p = -1;
			for (int b = 15; b >= 0; b--) begin
				if (req[15 - b]) p = bus_slot(b);
			end
			load_mask(16'hffc0);
			write_req(req);
			wait_irq();
			serve_once();
			vec_rd = 1'b1;
			@(negedge __clk);
			check_value("dad", dad, vector(p));
			check_value("rs", rs, exp_rs_after(p));
			vec_rd = 1'b0;
			clear_all();
		end
	endtask

	task automatic fetch_channel(input logic [15:0] data, input logic gpn, input int slot);
		rdt = data;
		zgpn_ = gpn;
		zw = 1'b1;
		rin = 1'b1;
		wait_dok();
		rin = 1'b0;
		@(negedge __clk);
		check_value("dok", dok, 0);
		load_mask(16'hffc0);
		wait_irq();
		check_value("przerw_z", przerw_z, slot >= 12 && slot <= 27); // channel level on top
		serve_once();
		vec_rd = 1'b1;
		@(negedge __clk);
		check_value("dad", dad, vector(slot));
		vec_rd = 1'b0;
		clear_all();
	endtask

	task automatic test_channel();
		logic [3:0] k;
		rng = xorshift(rng);
		k = rng[3:0];
		fetch_channel({11'b0, k, 1'b0}, 1'b0, 12 + k); // channel number in rdt 11..14
		fetch_channel(16'h0001, 1'b1, 3); // bit 15 high, bit 0 low
		fetch_channel(16'h8001, 1'b1, 29);
	endtask

	task automatic test_soft_int();
		soft_int(1'b1, 1'b0);
		check_value("bus_rz", bus_rz, 16'h0002); // slot 30
		soft_int(1'b0, 1'b1);
		check_value("bus_rz", bus_rz, 16'h0003); // slot 31 on top
		soft_int(1'b0, 1'b0);
		check_value("bus_rz", bus_rz, 16'h0000);
	endtask

	initial begin
		rng = 32'hbf69129f;
		init_inputs();
		wait_reset();
		test_reset();
		test_mask();
		test_soft_req();
		test_service();
		test_channel();
		test_soft_int();
		$display("All tests passed!");
		$finish;
	end

endmodule

/* intr.f */
hw/intr_pkg.sv
hw/chan_irq_if.sv
hw/intr_mask_reg.sv
hw/intr_slot.sv
hw/intr_prio_array.sv
hw/intr_vector_enc.sv
hw/chan_irq_fetch.sv
hw/intr_unit.sv
verif/tb_clk_gen.sv
verif/intr_unit_chk.sv
verif/intr_unit_tb.sv

/* Bender.yml */
package:
  name: intr

sources:
  - hw/intr_pkg.sv
  - hw/chan_irq_if.sv
  - hw/intr_mask_reg.sv
  - hw/intr_slot.sv
  - hw/intr_prio_array.sv
  - hw/intr_vector_enc.sv
  - hw/chan_irq_fetch.sv
  - hw/intr_unit.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/intr_unit_chk.sv
      - verif/intr_unit_tb.sv
